// File: dv/encoder_props.sv
/*
   concurrent checks on the encoder top level ports
   reset quiet, data word codes, fallback word marks and parities
   bound into encoder_top
*/

`timescale 1ns/1ps
`default_nettype none

module encoder_props
   import encoder_pkg::*;
(
   input logic              CLK_A,
   input logic              reset,
   input logic [WORD_W-1:0] data_word,
   input logic              data_load,
   input logic [WORD_W-1:0] fb_word,
   input logic              fb_load
);

   enc_word_u dw;

   assign dw = data_word;   // both views of the same word

   no_load_in_reset: assert property (@(posedge CLK_A)
      !reset |=> !data_load && !fb_load)
      else $error("load strobe following a reset cycle");

   ////////////////////////////////////////////////////////////////////////////
   // data word layout
   data_code_known: assert property (@(posedge CLK_A) disable iff (!reset)
      data_load |-> dw.bas.code == CODE_BAS_FULL || dw.bas.code == CODE_BAS_PART
                    || dw.sig.code == CODE_SIG_PAIR || dw.sig.code == CODE_SIG_SYNC)
      else $error("data word with unknown code");

   part_count_range: assert property (@(posedge CLK_A) disable iff (!reset)
      data_load && dw.bas.code == CODE_BAS_PART |->
         dw.bas.count >= 6'd1 && dw.bas.count <= 6'd4)
      else $error("partial baseline word count outside 1 to 4");

   sync_has_pattern: assert property (@(posedge CLK_A) disable iff (!reset)
      data_load && dw.sig.code == CODE_SIG_SYNC |-> dw.sig.upper == SYNC_PATTERN)
      else $error("sync word without the sync pattern");

   ////////////////////////////////////////////////////////////////////////////
   // fallback words
   fb_mark_parity: assert property (@(posedge CLK_A) disable iff (!reset)
      fb_load |-> fb_word[31:28] == FB_MARK
                  && fb_word[27] == ~^fb_word[25:13]
                  && fb_word[26] == ~^fb_word[12:0])
      else $error("fallback word with bad mark or parity");

   fb_load_single: assert property (@(posedge CLK_A) disable iff (!reset)
      fb_load |=> !fb_load)
      else $error("fallback load high for two cycles");

endmodule

bind encoder_top encoder_props u_props (.*);

`default_nettype wire

// File: dv/tb_clock.sv
/*
   testbench clock and reset
   20 ns clock, reset held low for 10 cycles
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
   output logic CLK_A,
   output logic reset
);

   initial
   begin
      CLK_A = 1'b0;
      forever #10 CLK_A = ~CLK_A;
   end

   initial
   begin
      reset = 1'b0;
      repeat (10) @(posedge CLK_A);
      reset <= 1'b1;   // released on an edge like any other input
   end

endmodule

`default_nettype wire

// File: dv/tb_encoder.sv
/*
   testbench for the output encoder
   directed and random stimulus, reference model with expected
   word queues, load checks and per-test reporting
*/

`timescale 1ns/1ps
`default_nettype none

module tb_encoder
   import encoder_pkg::*;
();

   localparam int N_FB_PAIRS    = 16;
   localparam int N_RANDOM      = 300;
   localparam int TOTAL_STROBES = 4 + 5 + 8 + 8 + 2*N_FB_PAIRS + 14 + N_RANDOM;
   localparam int CYCLE_LIMIT   = TOTAL_STROBES*4 + 200;

   logic              CLK_A;
   logic              reset;
   logic              sample_strobe;
   sample_t           sample;
   logic              baseline_flag;
   logic              fallback;
   logic [WORD_W-1:0] data_word;
   logic              data_load;
   logic [WORD_W-1:0] fb_word;
   logic              fb_load;

   // reference model
   logic [BAS_W-1:0]  m_bas [0:BAS_PER_WORD-1];
   int                m_cnt = 0;
   logic              m_sig_pend = 1'b0;
   sample_t           m_sig = '0;
   logic              m_half = 1'b0;
   sample_t           m_first = '0;
   logic [WORD_W-1:0] exp_data [$];
   int                exp_data_due [$];
   logic [WORD_W-1:0] exp_fb [$];
   int                exp_fb_due [$];

   logic [15:0]       lfsr = 16'd53;
   logic              fb_mode = 1'b0;
   string             cur_test = "reset";
   int                neg_cnt = 0;
   int                cycle_cnt = 0;
   int                errors = 0;
   int                err_mark = 0;
   int                checks = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   logic              data_seen = 1'b0;
   logic              fb_seen = 1'b0;

   tb_clock u_clock (.CLK_A(CLK_A), .reset(reset));

   encoder_top dut0 (
      .CLK_A(CLK_A), .reset(reset),
      .sample_strobe(sample_strobe), .sample(sample),
      .baseline_flag(baseline_flag), .fallback(fallback),
      .data_word(data_word), .data_load(data_load),
      .fb_word(fb_word), .fb_load(fb_load)
   );

   ////////////////////////////////////////////////////////////////////////////
   // random bits
   function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr_advance(lfsr);
      end
   endtask

   task automatic report_value(input string what, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] act);
      $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
   endtask

   task automatic report_latency(input int exp, input int act);
      $display("[FAIL] %s latency expected cycle %0d actual cycle %0d", cur_test, exp, act);
      errors++;
   endtask

   task automatic report_event(input string what);
      $display("%s: %s", cur_test, what);
      errors++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // word rules, one call per driven cycle
   task automatic model_step(input logic stb, input sample_t s, input logic bas,
                             input logic fb);
      logic [23:0]       payload;
      logic [WORD_W-1:0] w;
      logic              emit;
      payload = '0;
      w       = '0;
      emit    = 1'b0;
      if (fb)
      begin
         m_cnt      = 0;
         m_sig_pend = 1'b0;
         if (stb && !m_half)
         begin
            m_first = s;
            m_half  = 1'b1;
         end
         else if (stb)
         begin
            exp_fb.push_back({FB_MARK, ~^s, ~^m_first, s, m_first});
            exp_fb_due.push_back(neg_cnt + 3);
            m_half = 1'b0;
         end
      end
      else
      begin
         m_half = 1'b0;
         if (stb && bas && m_sig_pend)
         begin
            w          = {CODE_SIG_SYNC, SYNC_PATTERN, m_sig};
            emit       = 1'b1;
            m_sig_pend = 1'b0;
            m_bas[0]   = s[BAS_W-1:0];   // opens the next baseline word
            m_cnt      = 1;
         end
         else if (stb && bas && m_cnt == BAS_PER_WORD - 1)
         begin
            w     = {CODE_BAS_FULL, s[BAS_W-1:0], m_bas[3], m_bas[2], m_bas[1], m_bas[0]};
            emit  = 1'b1;
            m_cnt = 0;
         end
         else if (stb && bas)
         begin
            m_bas[m_cnt] = s[BAS_W-1:0];
            m_cnt++;
         end
         else if (stb && m_cnt != 0)
         begin
            for (int i = m_cnt - 1; i >= 0; i--)
            begin
               payload = {payload[17:0], m_bas[i]};
            end
            w          = {CODE_BAS_PART, 6'(m_cnt), payload};
            emit       = 1'b1;
            m_cnt      = 0;
            m_sig_pend = 1'b1;
            m_sig      = s;
         end
         else if (stb && m_sig_pend)
         begin
            w          = {CODE_SIG_PAIR, s, m_sig};
            emit       = 1'b1;
            m_sig_pend = 1'b0;
         end
         else if (stb)
         begin
            m_sig_pend = 1'b1;
            m_sig      = s;
         end
         if (emit)
         begin
            exp_data.push_back(w);
            exp_data_due.push_back(neg_cnt + 4);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   task automatic drive_cycle(input logic stb, input sample_t s, input logic bas);
      @(posedge CLK_A);
      sample_strobe <= stb;
      sample        <= s;
      baseline_flag <= bas;
      fallback      <= fb_mode;
      model_step(stb, s, bas, fb_mode);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, '0, 1'b0);
   endtask

   task automatic send_baseline();
      logic [15:0] v;
      draw_bits(BAS_W, v);
      drive_cycle(1'b1, {7'b0, v[BAS_W-1:0]}, 1'b1);
   endtask

   task automatic send_signal();
      logic [15:0] v;
      draw_bits(SAMPLE_W, v);
      drive_cycle(1'b1, v[SAMPLE_W-1:0], 1'b0);
   endtask

   task automatic random_gap();
      logic [15:0] v;
      draw_bits(2, v);
      if (v[1:0] == 2'd3)
         idle_cycles(2);
      else if (v[1:0] == 2'd2)
         idle_cycles(1);
   endtask

   // one fallback cycle drops whatever the stream packer holds
   task automatic clear_pending();
      fb_mode = 1'b1;
      idle_cycles(1);
      fb_mode = 1'b0;
      idle_cycles(1);
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      err_mark = errors;
   endtask

   task automatic finish_test();
      while (exp_data.size() != 0 || exp_fb.size() != 0)
         idle_cycles(1);
      idle_cycles(4);   // room for a stray load
      tests_run++;
      if (errors != err_mark)
         tests_failed++;
      $display("test %s finished, %0d errors", cur_test, errors - err_mark);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // output checks, sampled mid-cycle
   task automatic check_data_load();
      logic [WORD_W-1:0] exp_w;
      int                due;
      data_seen = 1'b1;
      if (exp_data.size() == 0)
      begin
         report_event("data word loaded with none expected");
      end
      else
      begin
         exp_w = exp_data.pop_front();
         due   = exp_data_due.pop_front();
         checks++;
         assert (data_word == exp_w) else report_value("data word", exp_w, data_word);
         assert (neg_cnt == due) else report_latency(due, neg_cnt);
      end
   endtask

   task automatic check_fb_load();
      logic [WORD_W-1:0] exp_w;
      int                due;
      fb_seen = 1'b1;
      if (exp_fb.size() == 0)
      begin
         report_event("fallback word loaded with none expected");
      end
      else
      begin
         exp_w = exp_fb.pop_front();
         due   = exp_fb_due.pop_front();
         checks++;
         assert (fb_word == exp_w) else report_value("fallback word", exp_w, fb_word);
         assert (neg_cnt == due) else report_latency(due, neg_cnt);
      end
   endtask

   always @(negedge CLK_A)
   begin
      neg_cnt = neg_cnt + 1;
      if (reset !== 1'b1)
      begin
         assert (data_load === 1'b0 && fb_load === 1'b0)
            else report_event("load strobe during reset");
      end
      else
      begin
         if (data_load)
            check_data_load();
         else if (!data_seen)
            assert (data_word == IDLE_WORD) else report_value("idle word", IDLE_WORD, data_word);
         if (fb_load)
            check_fb_load();
         else if (!fb_seen)
            assert (fb_word == '0) else report_value("idle fallback word", '0, fb_word);
      end
   end

   always @(posedge CLK_A)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles in test %s, run stopped", cycle_cnt, cur_test);
         $display("Simulation FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   initial
   begin
      sample_strobe = 1'b1;   // baseline strobes under reset, all ignored
      sample        = 13'h0015;
      baseline_flag = 1'b1;
      fallback      = 1'b0;
      @(posedge reset);
      sample_strobe <= 1'b0;
      sample        <= '0;
      baseline_flag <= 1'b0;

      start_test("reset");
      idle_cycles(5);
      repeat (4) send_baseline();   // not enough for a word
      idle_cycles(6);
      assert (!data_seen && !fb_seen) else report_event("word loaded before any could close");
      clear_pending();
      finish_test();

      start_test("full");
      repeat (5) send_baseline();
      finish_test();

      start_test("partial");
      repeat (2) send_baseline();
      send_signal();
      clear_pending();
      repeat (4) send_baseline();
      send_signal();
      clear_pending();
      finish_test();

      start_test("signal");
      send_signal();
      send_signal();
      send_signal();
      send_baseline();   // sync word, then sample 1 of the next word
      repeat (4) send_baseline();
      finish_test();

      start_test("fallback");
      fb_mode = 1'b1;
      repeat (N_FB_PAIRS)
      begin
         send_signal();
         random_gap();
         send_signal();
         random_gap();
      end
      send_signal();   // half pair, dropped below
      fb_mode = 1'b0;
      idle_cycles(1);
      fb_mode = 1'b1;
      send_signal();
      send_signal();
      fb_mode = 1'b0;
      repeat (3) send_baseline();
      clear_pending();
      repeat (5) send_baseline();
      send_signal();
      clear_pending();
      send_signal();
      send_baseline();
      finish_test();

      start_test("random");
      repeat (N_RANDOM)
      begin
         logic [15:0] v;
         draw_bits(2, v);
         if (v[1:0] != 2'd0)
            send_baseline();
         else
            send_signal();
         random_gap();
      end
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: encoder.f
source/encoder_pkg.sv
source/sample_capture.sv
source/stream_packer.sv
source/word_formatter.sv
source/fallback_packer.sv
source/encoder_top.sv
dv/tb_clock.sv
dv/encoder_props.sv
dv/tb_encoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the encoder testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_encoder -f encoder.f -o sim_encoder

# keep running past assertion errors so the testbench reports the result
./obj_dir/sim_encoder +verilator+error+limit+1000 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
   exit 0
else
   exit 1
fi

// File: source/encoder_pkg.sv
/*
   shared definitions for the output encoder:
   field widths, word codes, sync and idle patterns,
   sample type, word kind enum and the encoded word union
*/

`default_nettype none

package encoder_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   localparam int SAMPLE_W     = 13;
   localparam int BAS_W        = 6;   // baseline sample, low bits only
   localparam int WORD_W       = 32;
   localparam int BAS_PER_WORD = 5;

   ////////////////////////////////////////////////////////////////////////////
   // word codes and fixed patterns
   localparam logic [1:0]          CODE_BAS_FULL = 2'b01;
   localparam logic [1:0]          CODE_BAS_PART = 2'b10;
   localparam logic [5:0]          CODE_SIG_PAIR = 6'b001010;
   localparam logic [5:0]          CODE_SIG_SYNC = 6'b001011;
   localparam logic [SAMPLE_W-1:0] SYNC_PATTERN  = 13'b0101010101010;
   localparam logic [WORD_W-1:0]   IDLE_WORD     = 32'hF000_0000;
   localparam logic [3:0]          FB_MARK       = 4'b1111;

   typedef logic [SAMPLE_W-1:0] sample_t;

   typedef enum logic [1:0]
   {
      bas_full,
      bas_part,
      sig_pair,
      sig_sync
   } word_kind_t;

   // baseline layout, in a full word count and payload hold samples 5..1
   typedef struct packed
   {
      logic [1:0]  code;
      logic [5:0]  count;
      logic [23:0] payload;   // sample 1 lowest
   } bas_view_t;

   // signal layout
   typedef struct packed
   {
      logic [5:0] code;
      sample_t    upper;
      sample_t    lower;
   } sig_view_t;

   typedef union packed
   {
      bas_view_t bas;
      sig_view_t sig;
   } enc_word_u;

endpackage

`default_nettype wire

// File: source/encoder_top.sv
/*
   encoder top level
   capture stage feeding the stream packer with its formatter,
   and the fallback packer in parallel
*/

`timescale 1ns/1ps
`default_nettype none

module encoder_top
   import encoder_pkg::*;
(
   input  logic              CLK_A,
   input  logic              reset,
   input  logic              sample_strobe,
   input  sample_t           sample,
   input  logic              baseline_flag,
   input  logic              fallback,
   output logic [WORD_W-1:0] data_word,
   output logic              data_load,
   output logic [WORD_W-1:0] fb_word,
   output logic              fb_load
);

   logic                          cap_strobe;
   sample_t                       cap_sample;
   logic                          cap_baseline;
   logic                          cap_fallback;
   logic                          close_valid;
   word_kind_t                    close_kind;
   logic [2:0]                    close_count;
   logic [BAS_PER_WORD*BAS_W-1:0] close_bas;
   sample_t                       close_sig_hi;
   sample_t                       close_sig_lo;

   sample_capture u_capture (
      .CLK_A(CLK_A), .reset(reset),
      .sample_strobe(sample_strobe), .sample(sample),
      .baseline_flag(baseline_flag), .fallback(fallback),
      .cap_strobe(cap_strobe), .cap_sample(cap_sample),
      .cap_baseline(cap_baseline), .cap_fallback(cap_fallback)
   );

   stream_packer u_packer (
      .CLK_A(CLK_A), .reset(reset),
      .cap_strobe(cap_strobe), .cap_sample(cap_sample),
      .cap_baseline(cap_baseline), .cap_fallback(cap_fallback),
      .close_valid(close_valid), .close_kind(close_kind), .close_count(close_count),
      .close_bas(close_bas), .close_sig_hi(close_sig_hi), .close_sig_lo(close_sig_lo)
   );

   word_formatter u_formatter (
      .CLK_A(CLK_A), .reset(reset),
      .close_valid(close_valid), .close_kind(close_kind), .close_count(close_count),
      .close_bas(close_bas), .close_sig_hi(close_sig_hi), .close_sig_lo(close_sig_lo),
      .data_word(data_word), .data_load(data_load)
   );

   // fallback path, two cycles from the second strobe
   fallback_packer u_fallback (
      .CLK_A(CLK_A), .reset(reset),
      .cap_strobe(cap_strobe), .cap_sample(cap_sample), .cap_fallback(cap_fallback),
      .fb_word(fb_word), .fb_load(fb_load)
   );

endmodule

`default_nettype wire

// File: source/fallback_packer.sv
/*
   fallback mode stage
   pairs captured samples and adds the inverted-XOR parities
*/

`timescale 1ns/1ps
`default_nettype none

module fallback_packer
   import encoder_pkg::*;
(
   input  logic              CLK_A,
   input  logic              reset,
   input  logic              cap_strobe,
   input  sample_t           cap_sample,
   input  logic              cap_fallback,
   output logic [WORD_W-1:0] fb_word,
   output logic              fb_load
);

   sample_t first_buf;   // first sample of the pair
   logic    half;        // one sample waiting

   always_ff @(posedge CLK_A)
   begin
      if (!reset)
      begin
         first_buf <= '0;
         half      <= 1'b0;
         fb_word   <= '0;
         fb_load   <= 1'b0;
      end
      else if (!cap_fallback)
      begin
         first_buf <= '0;   // leaving fallback drops a half pair
         half      <= 1'b0;
         fb_load   <= 1'b0;
      end
      else
      begin
         fb_load <= 1'b0;
         if (cap_strobe && !half)
         begin
            first_buf <= cap_sample;
            half      <= 1'b1;
         end
         else if (cap_strobe)
         begin
            fb_word <= {FB_MARK, ~^cap_sample, ~^first_buf, cap_sample, first_buf};
            fb_load <= 1'b1;
            half    <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/sample_capture.sv
/*
   input register stage
   aligns sample, baseline flag and mode flag with the strobe
*/

`timescale 1ns/1ps
`default_nettype none

module sample_capture
   import encoder_pkg::*;
(
   input  logic    CLK_A,
   input  logic    reset,
   input  logic    sample_strobe,
   input  sample_t sample,
   input  logic    baseline_flag,
   input  logic    fallback,
   output logic    cap_strobe,
   output sample_t cap_sample,
   output logic    cap_baseline,
   output logic    cap_fallback
);

   always_ff @(posedge CLK_A)
   begin
      if (!reset)
      begin
         cap_strobe   <= 1'b0;
         cap_fallback <= 1'b0;
      end
      else
      begin
         cap_strobe   <= sample_strobe;
         cap_fallback <= fallback;   // mode follows the sample it came with
      end
   end

   always_ff @(posedge CLK_A)
   begin
      cap_sample   <= sample;
      cap_baseline <= baseline_flag;
   end

endmodule

`default_nettype wire

// File: source/stream_packer.sv
/*
   packing stage of the normal data stream
   holds pending baseline and signal samples, applies the word
   rules per strobed sample and registers one close event per word
*/

`timescale 1ns/1ps
`default_nettype none

module stream_packer
   import encoder_pkg::*;
(
   input  logic                          CLK_A,
   input  logic                          reset,
   input  logic                          cap_strobe,
   input  sample_t                       cap_sample,
   input  logic                          cap_baseline,
   input  logic                          cap_fallback,
   output logic                          close_valid,
   output word_kind_t                    close_kind,
   output logic [2:0]                    close_count,
   output logic [BAS_PER_WORD*BAS_W-1:0] close_bas,
   output sample_t                       close_sig_hi,
   output sample_t                       close_sig_lo
);

   logic [BAS_PER_WORD*BAS_W-1:0] bas_buf;   // sample i at slot i-1, empty slots zero
   logic [2:0]                    bas_cnt;
   logic                          sig_pend;
   sample_t                       sig_buf;
   logic [BAS_W-1:0]              new_bas;
   logic                          last_bas;

   assign new_bas  = cap_sample[BAS_W-1:0];
   assign last_bas = (bas_cnt == 3'(BAS_PER_WORD - 1));

   ////////////////////////////////////////////////////////////////////////////
   // pending state and close events
   always_ff @(posedge CLK_A)
   begin
      if (!reset)
      begin
         bas_buf     <= '0;
         bas_cnt     <= 3'd0;
         sig_pend    <= 1'b0;
         close_valid <= 1'b0;
      end
      else if (cap_fallback)
      begin
         // fallback mode owns the samples, drop anything pending here
         bas_buf     <= '0;
         bas_cnt     <= 3'd0;
         sig_pend    <= 1'b0;
         close_valid <= 1'b0;
      end
      else
      begin
         close_valid <= 1'b0;
         if (cap_strobe)
         begin
            if (cap_baseline && sig_pend)
            begin
               // lone signal closed by a baseline sample
               close_valid  <= 1'b1;
               close_kind   <= sig_sync;
               close_sig_hi <= cap_sample;
               close_sig_lo <= sig_buf;
               sig_pend     <= 1'b0;
               bas_buf      <= {{((BAS_PER_WORD-1)*BAS_W){1'b0}}, new_bas};
               bas_cnt      <= 3'd1;
            end
            else if (cap_baseline)
            begin
               if (last_bas)
               begin
                  close_valid <= 1'b1;
                  close_kind  <= bas_full;
                  close_count <= 3'(BAS_PER_WORD);
                  close_bas   <= {new_bas, bas_buf[(BAS_PER_WORD-1)*BAS_W-1:0]};
                  bas_buf     <= '0;
                  bas_cnt     <= 3'd0;
               end
               else
               begin
                  bas_buf[bas_cnt*BAS_W +: BAS_W] <= new_bas;
                  bas_cnt <= bas_cnt + 3'd1;
               end
            end
            else if (bas_cnt != 3'd0)
            begin
               // partial baseline word, signal waits for its partner
               close_valid <= 1'b1;
               close_kind  <= bas_part;
               close_count <= bas_cnt;
               close_bas   <= bas_buf;
               bas_buf     <= '0;
               bas_cnt     <= 3'd0;
               sig_pend    <= 1'b1;
            end
            else if (sig_pend)
            begin
               close_valid  <= 1'b1;
               close_kind   <= sig_pair;
               close_sig_hi <= cap_sample;   // newer sample on top
               close_sig_lo <= sig_buf;
               sig_pend     <= 1'b0;
            end
            else
            begin
               sig_pend <= 1'b1;
            end
         end
      end
   end

   // signal holding register
   always_ff @(posedge CLK_A)
   begin
      if (cap_strobe && !cap_baseline)
      begin
         sig_buf <= cap_sample;
      end
   end

endmodule

`default_nettype wire

// File: source/word_formatter.sv
/*
   output stage of the data stream
   builds the 32-bit word from a close event and registers it
*/

`timescale 1ns/1ps
`default_nettype none

module word_formatter
   import encoder_pkg::*;
(
   input  logic                          CLK_A,
   input  logic                          reset,
   input  logic                          close_valid,
   input  word_kind_t                    close_kind,
   input  logic [2:0]                    close_count,
   input  logic [BAS_PER_WORD*BAS_W-1:0] close_bas,
   input  sample_t                       close_sig_hi,
   input  sample_t                       close_sig_lo,
   output logic [WORD_W-1:0]             data_word,
   output logic                          data_load
);

   enc_word_u next_word;

   always_comb
   begin
      next_word = '0;
      case (close_kind)
         bas_full:
         begin
            next_word.bas.code                        = CODE_BAS_FULL;
            {next_word.bas.count, next_word.bas.payload} = close_bas;   // samples 5..1
         end
         bas_part:
         begin
            next_word.bas.code    = CODE_BAS_PART;
            next_word.bas.count   = {3'b000, close_count};
            next_word.bas.payload = close_bas[23:0];
         end
         sig_pair:
         begin
            next_word.sig.code  = CODE_SIG_PAIR;
            next_word.sig.upper = close_sig_hi;
            next_word.sig.lower = close_sig_lo;
         end
         default:   // sync word
         begin
            next_word.sig.code  = CODE_SIG_SYNC;
            next_word.sig.upper = SYNC_PATTERN;
            next_word.sig.lower = close_sig_lo;
         end
      endcase
   end

   always_ff @(posedge CLK_A)
   begin
      if (!reset)
      begin
         data_word <= IDLE_WORD;
         data_load <= 1'b0;
      end
      else
      begin
         data_load <= close_valid;
         if (close_valid)
         begin
            data_word <= next_word;   // held until the next load
         end
      end
   end

endmodule

`default_nettype wire
